// File: include/ooo_tracker_defines.svh
/*
 * Command tracker constants
 * Command word width, buffer depth and tag width
 */

`ifndef OOO_TRACKER_DEFINES_SVH
`define OOO_TRACKER_DEFINES_SVH

// One opcode bit plus a 15-bit body
`define OOO_CMD_WIDTH 16

// Number of slots in the out-of-order buffer
`define OOO_DEPTH 8

// Tag addresses one slot
`define OOO_TAG_WIDTH ($clog2(`OOO_DEPTH))

`endif

// File: source/ooo_tracker_pkg.sv
/*
 * Command tracker types
 * Opcode, the two body views and the command word union
 */

`default_nettype none

`include "ooo_tracker_defines.svh"

package ooo_tracker_pkg;

  // Byte carried by a store, count carried by a load
  localparam int DATA_WIDTH = 8;
  // Whatever is left after the opcode and the byte field
  localparam int ADDR_WIDTH = `OOO_CMD_WIDTH - 1 - DATA_WIDTH;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } opcode_t;

  // Store view of the body
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } store_body_t;

  // Load view of the same bits
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] count;
  } load_body_t;

  // Opcode in the MSB, body read through whichever view it selects
  typedef struct packed {
    opcode_t opcode;
    union packed {
      store_body_t store;
      load_body_t  load;
    } body;
  } command_t;

endpackage

`default_nettype wire

// File: source/first_free_slot.sv
/*
 * First free slot finder
 * Binary index of the lowest clear bit in a mask, with a found flag
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_defines.svh"

module first_free_slot #(
  parameter int WIDTH = `OOO_DEPTH,
  localparam int INDEX_WIDTH = $clog2(WIDTH)
) (
  input  wire  [WIDTH-1:0]       mask,
  output logic [INDEX_WIDTH-1:0] index,
  output logic                   found
);

  // Priority search, bit zero wins
  always_comb begin
    index = '0;
    found = 1'b0;
    // Walk downward so the lowest clear bit is the last one written
    for (int bit_index = WIDTH - 1; bit_index >= 0; bit_index--) begin
      if (!mask[bit_index]) begin
        index = INDEX_WIDTH'(bit_index);
        found = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/out_of_order_buffer.sv
/*
 * Out-of-order buffer
 * First-free allocation on write, indexed read with optional clear
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_defines.svh"

module out_of_order_buffer #(
  parameter int WIDTH = `OOO_CMD_WIDTH,
  parameter int DEPTH = `OOO_DEPTH,
  localparam int INDEX_WIDTH = $clog2(DEPTH)
) (
  input  wire                    clock,
  input  wire                    resetn,
  output logic                   full,
  output logic                   empty,
  // Write side
  input  wire                    write_enable,
  input  wire  [WIDTH-1:0]       write_data,
  output logic [INDEX_WIDTH-1:0] write_index,
  // Read side
  input  wire                    read_enable,
  input  wire                    read_clear,
  input  wire  [INDEX_WIDTH-1:0] read_index,
  output logic [WIDTH-1:0]       read_data,
  output logic                   read_error
);

  // Slot storage and occupancy
  logic [WIDTH-1:0] slots [DEPTH];
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] valid_next;

  logic slot_found;
  logic write_accept;

  // Lowest free slot, taken from the mask before any clear this cycle
  first_free_slot #(
    .WIDTH (DEPTH)
  ) u_first_free_slot (
    .mask  (valid),
    .index (write_index),
    .found (slot_found)
  );

  // Never overwrite a live slot even if the write side ignores full
  assign write_accept = write_enable && slot_found;

  // Occupancy update
  always_comb begin
    valid_next = valid;
    // Clear first, so a clear on a free slot cannot undo a new write there
    if (read_enable && read_clear) begin
      valid_next[read_index] = 1'b0;
    end
    if (write_accept) begin
      valid_next[write_index] = 1'b1;
    end
  end

  // Combinational read port
  assign read_data  = slots[read_index];
  // Reading a free slot is reported, the mask is left alone
  assign read_error = read_enable && !valid[read_index];

  // Payload store
  always_ff @(posedge clock) begin
    if (write_accept) begin
      slots[write_index] <= write_data;
    end
  end

  // Control state and status flags
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      valid <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      valid <= valid_next;
      // Flags follow the mask that the next cycle will see
      full  <= &valid_next;
      empty <= ~|valid_next;
    end
  end

  // Writer must respect the registered full flag
  a_no_write_when_full: assert property (
    @(posedge clock) disable iff (!resetn)
    write_enable |-> !full
  );

endmodule

`default_nettype wire

// File: source/command_issuer.sv
/*
 * Command issuer
 * Writes incoming commands into the buffer and reports the tag or a drop
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_defines.svh"

module command_issuer (
  input  wire                          clock,
  input  wire                          resetn,
  // Command input, plain strobe
  input  wire                          cmd_strobe,
  input  wire ooo_tracker_pkg::command_t cmd_word,
  // Buffer write side
  input  wire                          full,
  input  wire  [`OOO_TAG_WIDTH-1:0]    write_index,
  output logic                         write_enable,
  output ooo_tracker_pkg::command_t    write_data,
  // Issue report
  output logic                         issue_strobe,
  output logic [`OOO_TAG_WIDTH-1:0]    issue_tag,
  output logic                         cmd_dropped
);

  // No stall path, a command seen while full is lost
  assign write_enable = cmd_strobe && !full;
  assign write_data   = cmd_word;

  // One-cycle report after the sampling edge
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      issue_strobe <= 1'b0;
      cmd_dropped  <= 1'b0;
    end else begin
      issue_strobe <= write_enable;
      cmd_dropped  <= cmd_strobe && full;
    end
  end

  // Tag captured only on a write, held otherwise
  always_ff @(posedge clock) begin
    if (write_enable) begin
      issue_tag <= write_index;
    end
  end

  // A command is either issued or dropped, never both
  a_issue_xor_drop: assert property (
    @(posedge clock) disable iff (!resetn)
    !(issue_strobe && cmd_dropped)
  );

endmodule

`default_nettype wire

// File: source/completion_handler.sv
/*
 * Completion handler
 * Reads and frees the completed slot, decodes the command, registers the result
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_defines.svh"

module completion_handler (
  input  wire                                     clock,
  input  wire                                     resetn,
  // Completion input, plain strobe
  input  wire                                     complete_strobe,
  input  wire  [`OOO_TAG_WIDTH-1:0]               complete_tag,
  // Buffer read side
  output logic                                    read_enable,
  output logic                                    read_clear,
  output logic [`OOO_TAG_WIDTH-1:0]               read_index,
  input  wire ooo_tracker_pkg::command_t          read_data,
  input  wire                                     read_error,
  // Response
  output logic                                    resp_strobe,
  output logic [`OOO_TAG_WIDTH-1:0]               resp_tag,
  output logic [ooo_tracker_pkg::DATA_WIDTH-1:0]  resp_result,
  output logic                                    resp_error
);

  import ooo_tracker_pkg::*;

  logic [DATA_WIDTH-1:0] result_next;

  // Every completion consumes its slot
  assign read_enable = complete_strobe;
  assign read_clear  = 1'b1;
  assign read_index  = complete_tag;

  // Result rule, the body view is picked by the opcode
  always_comb begin
    case (read_data.opcode)
      OP_STORE: begin
        result_next = read_data.body.store.data;
      end
      OP_LOAD: begin
        // Address plus count, wraps at 256
        result_next = DATA_WIDTH'(read_data.body.load.addr) + read_data.body.load.count;
      end
      default: begin
        result_next = '0;
      end
    endcase
    // Stale slot contents are never reported
    if (read_error) begin
      result_next = '0;
    end
  end

  // Response control
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      resp_strobe <= 1'b0;
      resp_error  <= 1'b0;
    end else begin
      resp_strobe <= complete_strobe;
      resp_error  <= complete_strobe && read_error;
    end
  end

  // Response payload, held between completions
  always_ff @(posedge clock) begin
    if (complete_strobe) begin
      resp_tag    <= complete_tag;
      resp_result <= result_next;
    end
  end

  // An error only ever answers a completion from the previous cycle
  a_error_needs_completion: assert property (
    @(posedge clock) disable iff (!resetn)
    $rose(resp_error) |-> $past(complete_strobe)
  );

endmodule

`default_nettype wire

// File: source/ooo_tracker.sv
/*
 * Command tracker top level
 * Issuer, out-of-order buffer and completion handler wired together
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_defines.svh"

module ooo_tracker (
  input  wire                                    clock,
  input  wire                                    resetn,
  // Command side
  input  wire                                    cmd_strobe,
  input  wire ooo_tracker_pkg::command_t         cmd_word,
  output logic                                   issue_strobe,
  output logic [`OOO_TAG_WIDTH-1:0]              issue_tag,
  output logic                                   cmd_dropped,
  // Completion side
  input  wire                                    complete_strobe,
  input  wire  [`OOO_TAG_WIDTH-1:0]              complete_tag,
  output logic                                   resp_strobe,
  output logic [`OOO_TAG_WIDTH-1:0]              resp_tag,
  output logic [ooo_tracker_pkg::DATA_WIDTH-1:0] resp_result,
  output logic                                   resp_error,
  // Buffer status
  output logic                                   full,
  output logic                                   empty
);

  import ooo_tracker_pkg::*;

  // Issuer to buffer
  logic                      write_enable;
  command_t                  write_data;
  logic [`OOO_TAG_WIDTH-1:0] write_index;

  // Handler to buffer
  logic                      read_enable;
  logic                      read_clear;
  logic [`OOO_TAG_WIDTH-1:0] read_index;
  command_t                  read_data;
  logic                      read_error;

  command_issuer u_command_issuer (
    .clock        (clock),
    .resetn       (resetn),
    .cmd_strobe   (cmd_strobe),
    .cmd_word     (cmd_word),
    .full         (full),
    .write_index  (write_index),
    .write_enable (write_enable),
    .write_data   (write_data),
    .issue_strobe (issue_strobe),
    .issue_tag    (issue_tag),
    .cmd_dropped  (cmd_dropped)
  );

  // Buffer stores raw command words
  out_of_order_buffer #(
    .WIDTH (`OOO_CMD_WIDTH),
    .DEPTH (`OOO_DEPTH)
  ) u_out_of_order_buffer (
    .clock        (clock),
    .resetn       (resetn),
    .full         (full),
    .empty        (empty),
    .write_enable (write_enable),
    .write_data   (write_data),
    .write_index  (write_index),
    .read_enable  (read_enable),
    .read_clear   (read_clear),
    .read_index   (read_index),
    .read_data    (read_data),
    .read_error   (read_error)
  );

  completion_handler u_completion_handler (
    .clock           (clock),
    .resetn          (resetn),
    .complete_strobe (complete_strobe),
    .complete_tag    (complete_tag),
    .read_enable     (read_enable),
    .read_clear      (read_clear),
    .read_index      (read_index),
    .read_data       (read_data),
    .read_error      (read_error),
    .resp_strobe     (resp_strobe),
    .resp_tag        (resp_tag),
    .resp_result     (resp_result),
    .resp_error      (resp_error)
  );

endmodule

`default_nettype wire

// File: tests/clock_gen.sv
/*
 * Testbench clock source, free running from time zero
 */

`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clock
);

  // Starts low, first rising edge at half a period
  initial clock = 1'b0;
  always #(PERIOD / 2) clock = ~clock;

endmodule

`default_nettype wire

// File: tests/ooo_tracker_tb.sv
/*
 * Command tracker testbench
 * Reference model of the slots, monitor of issues and responses, directed tests
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_defines.svh"

module ooo_tracker_tb;

  localparam int DEPTH = `OOO_DEPTH;
  localparam int TAG_W = `OOO_TAG_WIDTH;
  localparam int DRAIN_LIMIT = 20;

  logic                      clock;
  logic                      resetn;
  logic                      cmd_strobe;
  logic [`OOO_CMD_WIDTH-1:0] cmd_word;
  logic                      issue_strobe;
  logic [TAG_W-1:0]          issue_tag;
  logic                      cmd_dropped;
  logic                      complete_strobe;
  logic [TAG_W-1:0]          complete_tag;
  logic                      resp_strobe;
  logic [TAG_W-1:0]          resp_tag;
  logic [7:0]                resp_result;
  logic                      resp_error;
  logic                      full;
  logic                      empty;

  // Model of the buffer slots
  logic        model_valid [DEPTH];
  logic [15:0] model_cmd [DEPTH];
  // Expected reports, -1 stands for a drop
  int          exp_issue [$];
  int          exp_resp_tag [$];
  logic [7:0]  exp_resp_result [$];
  bit          exp_resp_error [$];

  logic [TAG_W-1:0] order [DEPTH];
  int seed;
  int checks;
  int errors;
  int errors_before;
  int last_slot;

  clock_gen #(.PERIOD(100)) u_clock_gen (.clock(clock));

  ooo_tracker u_dut (
    .clock           (clock),
    .resetn          (resetn),
    .cmd_strobe      (cmd_strobe),
    .cmd_word        (cmd_word),
    .issue_strobe    (issue_strobe),
    .issue_tag       (issue_tag),
    .cmd_dropped     (cmd_dropped),
    .complete_strobe (complete_strobe),
    .complete_tag    (complete_tag),
    .resp_strobe     (resp_strobe),
    .resp_tag        (resp_tag),
    .resp_result     (resp_result),
    .resp_error      (resp_error),
    .full            (full),
    .empty           (empty)
  );

  // Store gives its data byte, load gives address plus count mod 256
  function automatic logic [7:0] predict_result(input logic [15:0] word);
    logic [8:0] sum;
    sum = {2'b00, word[14:8]} + {1'b0, word[7:0]};
    if (word[15]) begin
      return word[7:0];
    end
    return sum[7:0];
  endfunction

  // Lowest free model slot, -1 when all are taken
  function automatic int lowest_free();
    for (int i = 0; i < DEPTH; i++) begin
      if (!model_valid[TAG_W'(i)]) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic report_fail(input string msg);
    $display("FAIL @%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic random_command(input bit store, output logic [15:0] word);
    logic [31:0] r;
    r = $random(seed);
    word = {store, r[14:0]};
  endtask

  // One cycle of stimulus on the falling edge, model updated alongside
  task automatic drive_step(input bit do_issue, input logic [15:0] word,
                            input bit do_complete, input logic [TAG_W-1:0] tag);
    int  slot;
    bit  was_valid;
    was_valid = 1'b0;
    @(negedge clock);
    cmd_strobe      = do_issue;
    cmd_word        = word;
    complete_strobe = do_complete;
    complete_tag    = tag;
    // Completion judged on the slots as they stand before this edge
    if (do_complete) begin
      was_valid = model_valid[tag];
      exp_resp_tag.push_back(int'(tag));
      exp_resp_error.push_back(!was_valid);
      exp_resp_result.push_back(was_valid ? predict_result(model_cmd[tag]) : 8'h00);
    end
    // New command takes the lowest slot free before the clear
    if (do_issue) begin
      slot = lowest_free();
      exp_issue.push_back(slot);
      if (slot >= 0) begin
        model_valid[TAG_W'(slot)] = 1'b1;
        model_cmd[TAG_W'(slot)]   = word;
        last_slot = slot;
      end
    end
    if (was_valid) begin
      model_valid[tag] = 1'b0;
    end
  endtask

  // Strobes low, then wait for every expected report to show up
  task automatic wait_for_drain(input string what);
    int cycles;
    drive_step(1'b0, 16'h0000, 1'b0, '0);
    cycles = 0;
    while ((exp_issue.size() != 0 || exp_resp_tag.size() != 0) && cycles < DRAIN_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (exp_issue.size() != 0 || exp_resp_tag.size() != 0) begin
      $display("Timeout: DUT never answered every request during %s", what);
      errors++;
      exp_issue.delete();
      exp_resp_tag.delete();
      exp_resp_result.delete();
      exp_resp_error.delete();
    end
  endtask

  task automatic end_test(input int number, input string name);
    $display("test %0d (%s) done, %0d errors", number, name, errors - errors_before);
    errors_before = errors;
  endtask

  // Monitor, outputs are registered and stable on the falling edge
  always @(negedge clock) begin : monitor
    int exp_tag;
    if (resetn && (issue_strobe || cmd_dropped)) begin
      checks++;
      if (exp_issue.size() == 0) begin
        report_fail("issue report with no command outstanding");
      end else begin
        exp_tag = exp_issue.pop_front();
        if (exp_tag < 0 && (issue_strobe || !cmd_dropped)) begin
          report_fail("command should have been dropped");
        end else if (exp_tag >= 0 && (!issue_strobe || cmd_dropped)) begin
          report_fail($sformatf("command dropped, expected tag %0d", exp_tag));
        end else if (exp_tag >= 0 && int'(issue_tag) != exp_tag) begin
          report_fail($sformatf("issue tag %0d, expected %0d", issue_tag, exp_tag));
        end
      end
    end
    if (resetn && resp_strobe) begin
      checks++;
      if (exp_resp_tag.size() == 0) begin
        report_fail("response with no completion outstanding");
      end else if (int'(resp_tag) != exp_resp_tag[0] || resp_error != exp_resp_error[0] ||
                   resp_result != exp_resp_result[0]) begin
        report_fail($sformatf("response tag %0d err %0b result %02h, expected %0d %0b %02h",
                              resp_tag, resp_error, resp_result, exp_resp_tag[0],
                              exp_resp_error[0], exp_resp_result[0]));
      end
      if (exp_resp_tag.size() != 0) begin
        void'(exp_resp_tag.pop_front());
        void'(exp_resp_error.pop_front());
        void'(exp_resp_result.pop_front());
      end
    end
  end

  initial begin
    logic [15:0] word;
    seed            = 32'h317f1782;
    checks          = 0;
    errors          = 0;
    errors_before   = 0;
    last_slot       = 0;
    resetn          = 1'b0;
    cmd_strobe      = 1'b0;
    cmd_word        = '0;
    complete_strobe = 1'b0;
    complete_tag    = '0;
    for (int i = 0; i < DEPTH; i++) begin
      model_valid[TAG_W'(i)] = 1'b0;
      model_cmd[TAG_W'(i)]   = '0;
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;

    // Fill from empty, tags come out 0 to 7
    checks++;
    if (empty !== 1'b1 || full !== 1'b0) begin
      report_fail("flags after reset are not empty and not full");
    end
    for (int i = 0; i < DEPTH; i++) begin
      random_command(i[0], word);
      drive_step(1'b1, word, 1'b0, '0);
    end
    wait_for_drain("fill");
    checks++;
    if (full !== 1'b1 || empty !== 1'b0) begin
      report_fail("flags after eight issues are not full and not empty");
    end
    end_test(1, "fill from reset");

    // Ninth command has no slot
    random_command(1'b1, word);
    drive_step(1'b1, word, 1'b0, '0);
    wait_for_drain("drop");
    checks++;
    if (full !== 1'b1) begin
      report_fail("full cleared by a dropped command");
    end
    end_test(2, "drop when full");

    // Complete everything in a shuffled order
    for (int i = 0; i < DEPTH; i++) begin
      order[i] = TAG_W'(i);
    end
    for (int i = DEPTH - 1; i > 0; i--) begin
      logic [TAG_W-1:0] pick;
      logic [TAG_W-1:0] held;
      pick = TAG_W'($unsigned($random(seed)) % (i + 1));
      held = order[TAG_W'(i)];
      order[TAG_W'(i)] = order[pick];
      order[pick] = held;
    end
    for (int i = 0; i < DEPTH; i++) begin
      drive_step(1'b0, 16'h0000, 1'b1, order[TAG_W'(i)]);
    end
    wait_for_drain("random completion");
    checks++;
    if (empty !== 1'b1 || full !== 1'b0) begin
      report_fail("flags after all completions are not empty and not full");
    end
    end_test(3, "random completion order");

    // Stale tag, then a good round trip
    drive_step(1'b0, 16'h0000, 1'b1, TAG_W'($unsigned($random(seed))));
    random_command(1'b0, word);
    drive_step(1'b1, word, 1'b0, '0);
    wait_for_drain("stale completion");
    drive_step(1'b0, 16'h0000, 1'b1, TAG_W'(last_slot));
    wait_for_drain("recovery completion");
    end_test(4, "completion of a free tag");

    // Refill holes out of order, one issue shares an edge with a completion
    for (int i = 0; i < DEPTH; i++) begin
      random_command(i[1], word);
      drive_step(1'b1, word, 1'b0, '0);
    end
    drive_step(1'b0, 16'h0000, 1'b1, 3'd5);
    drive_step(1'b0, 16'h0000, 1'b1, 3'd2);
    drive_step(1'b0, 16'h0000, 1'b1, 3'd6);
    random_command(1'b1, word);
    drive_step(1'b1, word, 1'b0, '0);
    random_command(1'b0, word);
    drive_step(1'b1, word, 1'b1, 3'd0);
    random_command(1'b1, word);
    drive_step(1'b1, word, 1'b0, '0);
    random_command(1'b0, word);
    drive_step(1'b1, word, 1'b0, '0);
    wait_for_drain("refill");
    for (int i = DEPTH - 1; i >= 0; i--) begin
      drive_step(1'b0, 16'h0000, 1'b1, TAG_W'(i));
    end
    wait_for_drain("final drain");
    checks++;
    if (empty !== 1'b1) begin
      report_fail("empty not set after final drain");
    end
    end_test(5, "refill of freed slots");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ooo_tracker.f
+incdir+include
source/ooo_tracker_pkg.sv
source/first_free_slot.sv
source/out_of_order_buffer.sv
source/command_issuer.sv
source/completion_handler.sv
source/ooo_tracker.sv
tests/clock_gen.sv
tests/ooo_tracker_tb.sv

// File: Makefile
# Verilator build and run of the command tracker testbench

VERILATOR ?= verilator
TOP       ?= ooo_tracker_tb
FILELIST  ?= ooo_tracker.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: sim clean

# Build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
